/* verilog/fpv_pkg.sv */
package fpv_pkg;

    // fp16 field layout
    localparam int FP_W    = 16;
    localparam int EXP_W   = 5;
    localparam int MANT_W  = 10;
    // Hidden bit plus stored mantissa plus 14 guard bits
    localparam int ALIGN_W = MANT_W + 1 + 14;

    // Canonical encodings
    localparam logic [FP_W-1:0] QNAN   = 16'h7E00;
    localparam logic [FP_W-1:0] P_ZERO = 16'h0000;
    localparam logic [FP_W-1:0] N_ZERO = 16'h8000;
    localparam logic [FP_W-1:0] P_INF  = 16'h7C00;

    // Vector shape and lane latency in clock edges
    localparam int N_LANES  = 4;
    localparam int LANE_LAT = 4;

    // AXI4-Lite register map, 32-bit data
    localparam int                 AXI_AW        = 8;
    localparam logic [AXI_AW-1:0] ADDR_CTRL     = 8'h00;
    localparam logic [AXI_AW-1:0] ADDR_STATUS   = 8'h04;
    localparam logic [AXI_AW-1:0] ADDR_OPA_BASE = 8'h10;
    localparam logic [AXI_AW-1:0] ADDR_OPB_BASE = 8'h20;
    localparam logic [AXI_AW-1:0] ADDR_RES_BASE = 8'h30;

endpackage

/* verilog/fp16_add_lane.sv */
`timescale 1ns/1ps

module fp16_add_lane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [fpv_pkg::FP_W-1:0] a,
    input  logic [fpv_pkg::FP_W-1:0] b,
    output logic [fpv_pkg::FP_W-1:0] sum
);
    import fpv_pkg::*;

    localparam int GUARD_W = ALIGN_W - MANT_W - 1;
    localparam int LEAD_W  = $clog2(ALIGN_W + 1);
    localparam int SEXP_W  = EXP_W + 2;
    localparam int EXP_MAX = 2**EXP_W - 1;
    localparam int WARM_W  = $clog2(LANE_LAT + 1);
    localparam logic [EXP_W-1:0] EXP_ONES = '1;

    // Operand fields
    logic              sign_a, sign_b;
    logic [EXP_W-1:0]  exp_a, exp_b;
    logic [MANT_W-1:0] man_a, man_b;
    logic              zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;
    logic              a_ge_b;

    assign sign_a = a[FP_W-1];
    assign sign_b = b[FP_W-1];
    assign exp_a  = a[FP_W-2:MANT_W];
    assign exp_b  = b[FP_W-2:MANT_W];
    assign man_a  = a[MANT_W-1:0];
    assign man_b  = b[MANT_W-1:0];
    assign zero_a = (exp_a == '0) && (man_a == '0);
    assign zero_b = (exp_b == '0) && (man_b == '0);
    assign inf_a  = (exp_a == EXP_ONES) && (man_a == '0);
    assign inf_b  = (exp_b == EXP_ONES) && (man_b == '0);
    assign nan_a  = (exp_a == EXP_ONES) && (man_a != '0);
    assign nan_b  = (exp_b == EXP_ONES) && (man_b != '0);
    // Magnitude order ignores the sign bit
    assign a_ge_b = {exp_a, man_a} >= {exp_b, man_b};

    // ----------------------------------------
    // Stage 1 order, align, special cases
    // ----------------------------------------
    logic [EXP_W-1:0]  exp_l, exp_diff;
    logic [MANT_W:0]   hid_l, hid_s;
    logic              sign_l;
    logic              byp_d;
    logic [FP_W-1:0]   byp_val_d;

    always_comb begin
        if (a_ge_b) begin
            exp_l    = exp_a;
            exp_diff = exp_a - exp_b;
            hid_l    = {|exp_a, man_a};
            hid_s    = {|exp_b, man_b};
            sign_l   = sign_a;
        end else begin
            exp_l    = exp_b;
            exp_diff = exp_b - exp_a;
            hid_l    = {|exp_b, man_b};
            hid_s    = {|exp_a, man_a};
            sign_l   = sign_b;
        end
        // Bypass table, first match wins
        byp_d     = 1'b1;
        byp_val_d = QNAN;
        if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
            byp_val_d = QNAN;
        end else if (inf_a) begin
            byp_val_d = a;
        end else if (inf_b) begin
            byp_val_d = b;
        end else if (zero_a && !zero_b) begin
            byp_val_d = b;
        end else if (zero_b && !zero_a) begin
            byp_val_d = a;
        end else begin
            // Both zero goes down the datapath for the zero sign rule
            byp_d = 1'b0;
        end
    end

    logic               s1_byp, s1_sign, s1_sub, s1_nzero;
    logic [FP_W-1:0]    s1_byp_val;
    logic [EXP_W-1:0]   s1_exp;
    logic [ALIGN_W-1:0] s1_man_l, s1_man_s;

    always_ff @(posedge clk) begin
        s1_byp     <= byp_d;
        s1_byp_val <= byp_val_d;
        s1_exp     <= exp_l;
        s1_sign    <= sign_l;
        s1_sub     <= sign_a != sign_b;
        s1_nzero   <= zero_a && zero_b && sign_a && sign_b;
        s1_man_l   <= {hid_l, {GUARD_W{1'b0}}};
        // Smaller operand shifted right by the exponent gap
        s1_man_s   <= {hid_s, {GUARD_W{1'b0}}} >> exp_diff;
    end

    // ----------------------------------------
    // Stage 2 add or subtract
    // ----------------------------------------
    logic             s2_byp, s2_sign, s2_nzero;
    logic [FP_W-1:0]  s2_byp_val;
    logic [EXP_W-1:0] s2_exp;
    logic [ALIGN_W:0] s2_man;

    always_ff @(posedge clk) begin
        s2_byp     <= s1_byp;
        s2_byp_val <= s1_byp_val;
        s2_exp     <= s1_exp;
        s2_sign    <= s1_sign;
        s2_nzero   <= s1_nzero;
        // Larger magnitude is first, so the difference never goes negative
        if (s1_sub) begin
            s2_man <= {1'b0, s1_man_l} - {1'b0, s1_man_s};
        end else begin
            s2_man <= {1'b0, s1_man_l} + {1'b0, s1_man_s};
        end
    end

    // ----------------------------------------
    // Stage 3 normalize
    // ----------------------------------------
    logic [LEAD_W-1:0]        lead;
    logic                     found;
    logic [ALIGN_W:0]         shifted;
    logic signed [SEXP_W-1:0] norm_exp;

    always_comb begin
        lead  = '0;
        found = 1'b0;
        // Leading one, carry bit included
        for (int i = ALIGN_W; i >= 0; i--) begin
            if (s2_man[i] && !found) begin
                lead  = LEAD_W'(i);
                found = 1'b1;
            end
        end
        // Move the leading one to bit ALIGN_W, hidden bit sits one below after the slice
        shifted  = s2_man << (ALIGN_W - lead);
        norm_exp = SEXP_W'(int'(s2_exp) + int'(lead) - (ALIGN_W - 1));
    end

    logic                     s3_byp, s3_sign, s3_nzero, s3_zero;
    logic [FP_W-1:0]          s3_byp_val;
    logic signed [SEXP_W-1:0] s3_exp;
    logic [ALIGN_W-1:0]       s3_man;

    always_ff @(posedge clk) begin
        s3_byp     <= s2_byp;
        s3_byp_val <= s2_byp_val;
        s3_sign    <= s2_sign;
        s3_nzero   <= s2_nzero;
        s3_zero    <= !found;
        s3_exp     <= norm_exp;
        s3_man     <= shifted[ALIGN_W:1];
    end

    // ----------------------------------------
    // Stage 4 truncate and pack
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (s3_byp) begin
            sum <= s3_byp_val;
        end else if (s3_zero) begin
            // Exact cancellation is +0, only -0 plus -0 stays negative
            sum <= s3_nzero ? N_ZERO : P_ZERO;
        end else if (s3_exp >= EXP_MAX) begin
            sum <= {s3_sign, P_INF[FP_W-2:0]};
        end else if (s3_exp <= 0) begin
            // Flush to zero, sign kept
            sum <= s3_sign ? N_ZERO : P_ZERO;
        end else begin
            sum <= {s3_sign, s3_exp[EXP_W-1:0], s3_man[ALIGN_W-2 -: MANT_W]};
        end
    end

    // Edges since reset release, saturating at the pipeline depth
    logic [WARM_W-1:0] warm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            warm <= '0;
        end else if (warm != WARM_W'(LANE_LAT)) begin
            warm <= warm + 1'b1;
        end
    end

    a_sum_known: assert property (@(posedge clk) disable iff (!rst_n)
        (warm == WARM_W'(LANE_LAT)) |-> !$isunknown(sum));

endmodule

/* verilog/fpv_issue.sv */
`timescale 1ns/1ps

module fpv_issue (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start,
    input  logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] opa_regs,
    input  logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] opb_regs,
    output logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] lane_a,
    output logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] lane_b,
    output logic                                      issue
);

    // Lane inputs start at zero so the lanes flush clean out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_a <= '0;
            lane_b <= '0;
            issue  <= 1'b0;
        end else begin
            // One pulse per start
            issue <= start;
            if (start) begin
                // Snapshot so later register writes leave this vector alone
                lane_a <= opa_regs;
                lane_b <= opb_regs;
            end
        end
    end

    // Write back-pressure keeps start to single pulses, so issue never repeats on the next edge
    a_issue_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        issue |=> !issue);

endmodule

/* verilog/fpv_collect.sv */
`timescale 1ns/1ps

module fpv_collect (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      issue,
    input  logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] lane_sum,
    output logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] res_regs,
    output logic [7:0]                                done_count,
    output logic                                      busy,
    output logic                                      nan_flag
);
    import fpv_pkg::*;

    localparam logic [EXP_W-1:0] EXP_ONES = '1;

    // One bit per vector in flight, oldest at the top
    logic [LANE_LAT-1:0] vld_pipe;
    logic                any_nan;

    always_comb begin
        any_nan = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            if (lane_sum[i*FP_W+MANT_W +: EXP_W] == EXP_ONES &&
                lane_sum[i*FP_W +: MANT_W] != '0) begin
                any_nan = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe   <= '0;
            res_regs   <= {N_LANES{P_ZERO}};
            done_count <= '0;
            nan_flag   <= 1'b0;
        end else begin
            vld_pipe <= {vld_pipe[LANE_LAT-2:0], issue};
            // Sums of the oldest vector are on the lane outputs now
            if (vld_pipe[LANE_LAT-1]) begin
                res_regs   <= lane_sum;
                done_count <= done_count + 8'd1;
                if (any_nan) begin
                    nan_flag <= 1'b1;
                end
            end
        end
    end

    // Issue cycle counted too, so a status read right after start sees busy
    assign busy = issue || (|vld_pipe);

endmodule

/* verilog/fpv_axil_regs.sv */
`timescale 1ns/1ps

module fpv_axil_regs (
    input  logic                                      clk,
    input  logic                                      rst_n,
    // AXI4-Lite slave
    input  logic [fpv_pkg::AXI_AW-1:0]                aw_addr,
    input  logic                                      aw_valid,
    output logic                                      aw_ready,
    input  logic [31:0]                               w_data,
    input  logic [3:0]                                w_strb,
    input  logic                                      w_valid,
    output logic                                      w_ready,
    output logic [1:0]                                b_resp,
    output logic                                      b_valid,
    input  logic                                      b_ready,
    input  logic [fpv_pkg::AXI_AW-1:0]                ar_addr,
    input  logic                                      ar_valid,
    output logic                                      ar_ready,
    output logic [31:0]                               r_data,
    output logic [1:0]                                r_resp,
    output logic                                      r_valid,
    input  logic                                      r_ready,
    // Read-back from the collector
    input  logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] res_regs,
    input  logic [7:0]                                done_count,
    input  logic                                      busy,
    input  logic                                      nan_flag,
    // To the feeder
    output logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] opa_regs,
    output logic [fpv_pkg::N_LANES*fpv_pkg::FP_W-1:0] opb_regs,
    output logic                                      start
);
    import fpv_pkg::*;

    logic        wr_take, rd_take;
    logic [31:0] rd_word;

    // ----------------------------------------
    // Write channel
    // ----------------------------------------
    // Address and data together, stalled while a response waits
    assign wr_take  = aw_valid && w_valid && !b_valid;
    assign aw_ready = wr_take;
    assign w_ready  = wr_take;
    assign b_resp   = 2'b00;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa_regs <= '0;
            opb_regs <= '0;
            start    <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            start <= wr_take && (aw_addr == ADDR_CTRL) && w_strb[0] && w_data[0];
            if (wr_take) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_take) begin
                for (int i = 0; i < N_LANES; i++) begin
                    // Byte lanes 0 and 1 only
                    if (aw_addr == AXI_AW'(ADDR_OPA_BASE + 4*i)) begin
                        if (w_strb[0]) opa_regs[i*FP_W +: 8] <= w_data[7:0];
                        if (w_strb[1]) opa_regs[i*FP_W+8 +: 8] <= w_data[15:8];
                    end
                    if (aw_addr == AXI_AW'(ADDR_OPB_BASE + 4*i)) begin
                        if (w_strb[0]) opb_regs[i*FP_W +: 8] <= w_data[7:0];
                        if (w_strb[1]) opb_regs[i*FP_W+8 +: 8] <= w_data[15:8];
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Read channel
    // ----------------------------------------
    assign rd_take  = ar_valid && !r_valid;
    assign ar_ready = rd_take;
    assign r_resp   = 2'b00;

    // Unmapped and CTRL read as zero
    always_comb begin
        rd_word = '0;
        if (ar_addr == ADDR_STATUS) begin
            rd_word = {22'd0, nan_flag, busy, done_count};
        end
        for (int i = 0; i < N_LANES; i++) begin
            if (ar_addr == AXI_AW'(ADDR_OPA_BASE + 4*i)) begin
                rd_word = {{(32-FP_W){1'b0}}, opa_regs[i*FP_W +: FP_W]};
            end
            if (ar_addr == AXI_AW'(ADDR_OPB_BASE + 4*i)) begin
                rd_word = {{(32-FP_W){1'b0}}, opb_regs[i*FP_W +: FP_W]};
            end
            if (ar_addr == AXI_AW'(ADDR_RES_BASE + 4*i)) begin
                rd_word = {{(32-FP_W){1'b0}}, res_regs[i*FP_W +: FP_W]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (rd_take) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            r_data <= rd_word;
        end
    end

    // Responses wait for the host
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid);
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_data));

endmodule

/* verilog/fpv_top.sv */
`timescale 1ns/1ps

module fpv_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fpv_pkg::AXI_AW-1:0] aw_addr,
    input  logic                       aw_valid,
    output logic                       aw_ready,
    input  logic [31:0]                w_data,
    input  logic [3:0]                 w_strb,
    input  logic                       w_valid,
    output logic                       w_ready,
    output logic [1:0]                 b_resp,
    output logic                       b_valid,
    input  logic                       b_ready,
    input  logic [fpv_pkg::AXI_AW-1:0] ar_addr,
    input  logic                       ar_valid,
    output logic                       ar_ready,
    output logic [31:0]                r_data,
    output logic [1:0]                 r_resp,
    output logic                       r_valid,
    input  logic                       r_ready
);
    import fpv_pkg::*;

    logic [N_LANES*FP_W-1:0] opa_regs, opb_regs;
    logic [N_LANES*FP_W-1:0] lane_a, lane_b, lane_sum;
    logic [N_LANES*FP_W-1:0] res_regs;
    logic [7:0]              done_count;
    logic                    start, issue, busy, nan_flag;

    fpv_axil_regs u_regs (
        .clk, .rst_n,
        .aw_addr, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_valid, .w_ready,
        .b_resp, .b_valid, .b_ready,
        .ar_addr, .ar_valid, .ar_ready,
        .r_data, .r_resp, .r_valid, .r_ready,
        .res_regs, .done_count, .busy, .nan_flag,
        .opa_regs, .opb_regs, .start
    );

    fpv_issue u_issue (
        .clk, .rst_n, .start, .opa_regs, .opb_regs, .lane_a, .lane_b, .issue
    );

    // One adder per fp16 slot
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        fp16_add_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (lane_a[i*FP_W +: FP_W]),
            .b     (lane_b[i*FP_W +: FP_W]),
            .sum   (lane_sum[i*FP_W +: FP_W])
        );
    end

    fpv_collect u_collect (
        .clk, .rst_n, .issue, .lane_sum, .res_regs, .done_count, .busy, .nan_flag
    );

endmodule

/* verification/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset low across the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* verification/tb_fpv_top.sv */
`timescale 1ns/1ps

module tb_fpv_top;
    import fpv_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic              clk, rst_n;
    logic [AXI_AW-1:0] aw_addr, ar_addr;
    logic              aw_valid, aw_ready, w_valid, w_ready;
    logic [31:0]       w_data, r_data;
    logic [3:0]        w_strb;
    logic [1:0]        b_resp, r_resp;
    logic              b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready;

    // Golden vectors with lane 0 in the low 16 bits
    logic [N_LANES*FP_W-1:0] gold_a[$], gold_b[$], gold_sum[$];
    // Running model of the status register
    logic [7:0]              done_seen;
    logic                    nan_seen;

    tb_clkgen u_clkgen (.clk, .rst_n);

    fpv_top uut (
        .clk, .rst_n,
        .aw_addr, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_valid, .w_ready,
        .b_resp, .b_valid, .b_ready,
        .ar_addr, .ar_valid, .ar_ready,
        .r_data, .r_resp, .r_valid, .r_ready
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic random_gap();
        int gap;
        gap = $urandom_range(3, 0);
        repeat (gap) next_cycle();
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            abort_run($sformatf("MISMATCH at %0t: %s read %h, expected %h",
                                $time, name, got, want));
        end
    endtask

    // ----------------------------------------
    // AXI4-Lite host
    // ----------------------------------------
    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data);
        int n;
        aw_addr  = addr;
        w_data   = data;
        w_strb   = 4'hF;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        n = 0;
        // Ready sampled mid-cycle and the transfer happens on the next edge
        @(negedge clk);
        while (!(aw_ready && w_ready)) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                abort_run($sformatf("Write address and data channel hung at address %h", addr));
            end
            @(negedge clk);
        end
        next_cycle();
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        random_gap();
        b_ready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!b_valid) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                abort_run($sformatf("Write response channel hung at address %h", addr));
            end
            @(negedge clk);
        end
        check_word("BRESP", {30'd0, b_resp}, 32'd0);
        next_cycle();
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data);
        int n;
        ar_addr  = addr;
        ar_valid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!ar_ready) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                abort_run($sformatf("Read address channel hung at address %h", addr));
            end
            @(negedge clk);
        end
        next_cycle();
        ar_valid = 1'b0;
        random_gap();
        r_ready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!r_valid) begin
            n++;
            if (n >= WAIT_LIMIT) begin
                abort_run($sformatf("Read data channel hung at address %h", addr));
            end
            @(negedge clk);
        end
        data = r_data;
        check_word("RRESP", {30'd0, r_resp}, 32'd0);
        next_cycle();
        r_ready = 1'b0;
    endtask

    task automatic read_and_check(input logic [AXI_AW-1:0] addr, input string name,
                                  input logic [31:0] want);
        logic [31:0] got;
        axi_read(addr, got);
        check_word(name, got, want);
    endtask

    // ----------------------------------------
    // Vector helpers
    // ----------------------------------------
    // NaN is an all-ones exponent with a nonzero mantissa
    function automatic logic sums_have_nan(input logic [N_LANES*FP_W-1:0] sums);
        logic found;
        found = 1'b0;
        for (int i = 0; i < N_LANES; i++) begin
            if (sums[i*FP_W+10 +: 5] == 5'h1F && sums[i*FP_W +: 10] != '0) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic read_golden();
        int          fd, code;
        string       line;
        logic [15:0] v [12];
        fd = $fopen("verification/fpv_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the golden vector file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            // Comment lines start with a hash
            if (line.substr(0, 0) == "#") continue;
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                           v[0], v[1], v[2], v[3], v[4], v[5],
                           v[6], v[7], v[8], v[9], v[10], v[11]);
            if (code == 12) begin
                gold_a.push_back({v[3], v[2], v[1], v[0]});
                gold_b.push_back({v[7], v[6], v[5], v[4]});
                gold_sum.push_back({v[11], v[10], v[9], v[8]});
            end else if (code > 0) begin
                abort_run($sformatf("Malformed golden line: %s", line));
            end
        end
        $fclose(fd);
        if (gold_a.size() < 2) begin
            abort_run("Golden file holds fewer than two vectors");
        end
    endtask

    // Writes both operand sets and reads each one back
    task automatic load_operands(input int k);
        logic [15:0] opa, opb;
        for (int i = 0; i < N_LANES; i++) begin
            opa = gold_a[k][i*FP_W +: FP_W];
            opb = gold_b[k][i*FP_W +: FP_W];
            axi_write(AXI_AW'(ADDR_OPA_BASE + 4*i), {16'd0, opa});
            axi_write(AXI_AW'(ADDR_OPB_BASE + 4*i), {16'd0, opb});
            read_and_check(AXI_AW'(ADDR_OPA_BASE + 4*i), $sformatf("OPA%0d", i), {16'd0, opa});
            read_and_check(AXI_AW'(ADDR_OPB_BASE + 4*i), $sformatf("OPB%0d", i), {16'd0, opb});
        end
    endtask

    // Polls STATUS until idle with the expected count
    task automatic wait_for_done(input logic [7:0] target);
        logic [31:0] status;
        int          polls;
        polls = 0;
        axi_read(ADDR_STATUS, status);
        while (status[8] || status[7:0] != target) begin
            polls++;
            if (polls >= WAIT_LIMIT) begin
                abort_run($sformatf("Vector never completed, done count %0d, waiting for %0d",
                                    status[7:0], target));
            end
            axi_read(ADDR_STATUS, status);
        end
        read_and_check(ADDR_STATUS, "STATUS", {22'd0, nan_seen, 1'b0, done_seen});
    endtask

    task automatic check_results(input int k);
        for (int i = 0; i < N_LANES; i++) begin
            read_and_check(AXI_AW'(ADDR_RES_BASE + 4*i), $sformatf("RES%0d", i),
                           {16'd0, gold_sum[k][i*FP_W +: FP_W]});
        end
    endtask

    task automatic run_single(input int k);
        load_operands(k);
        axi_write(ADDR_CTRL, 32'd1);
        done_seen = done_seen + 8'd1;
        nan_seen  = nan_seen | sums_have_nan(gold_sum[k]);
        wait_for_done(done_seen);
        check_results(k);
    endtask

    // Second vector's operands land while the first may be in flight
    task automatic run_pair(input int k0, input int k1);
        load_operands(k0);
        axi_write(ADDR_CTRL, 32'd1);
        load_operands(k1);
        axi_write(ADDR_CTRL, 32'd1);
        done_seen = done_seen + 8'd2;
        nan_seen  = nan_seen | sums_have_nan(gold_sum[k0]) | sums_have_nan(gold_sum[k1]);
        wait_for_done(done_seen);
        check_results(k1);
    endtask

    // Idle status, cleared results and unmapped space right after reset
    task automatic check_after_reset();
        assert (!b_valid && !r_valid) else begin
            abort_run($sformatf("MISMATCH at %0t: response valid high after reset", $time));
        end
        read_and_check(ADDR_STATUS, "STATUS", 32'd0);
        // Results come out of reset as positive zero
        for (int i = 0; i < N_LANES; i++) begin
            read_and_check(AXI_AW'(ADDR_RES_BASE + 4*i), $sformatf("RES%0d", i), 32'd0);
        end
        read_and_check(8'h08, "unmapped 0x08", 32'd0);
        read_and_check(8'h0C, "unmapped 0x0C", 32'd0);
        read_and_check(8'h40, "unmapped 0x40", 32'd0);
        read_and_check(8'hFC, "unmapped 0xFC", 32'd0);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int n;
        aw_addr  = '0;
        aw_valid = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar_addr  = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        done_seen = '0;
        nan_seen  = 1'b0;
        void'($urandom(56042));
        read_golden();

        n = 0;
        while (rst_n !== 1'b1) begin
            if (n >= WAIT_LIMIT) begin
                abort_run("Reset was never released");
            end
            @(posedge clk);
            n++;
        end
        next_cycle();

        check_after_reset();
        // First vector after reset also checks a done count of 1
        for (int k = 0; k < gold_a.size(); k++) begin
            run_single(k);
        end
        run_pair(0, 1);

        $display("No errors");
        $finish;
    end

endmodule

/* verification/fpv_golden.txt */
# Columns: a0 a1 a2 a3 b0 b1 b2 b3 sum0 sum1 sum2 sum3, fp16 hex, lane 0 first
# Sums truncate, saturate to infinity and flush underflow to signed zero
3C00 4200 3E00 4900 3C00 BC00 3400 4A00 4000 4000 3F00 4D80
3C01 4001 4500 3C00 BC00 C000 C500 C200 1400 1800 0000 C000
3A00 4700 C500 4400 3800 BC00 C600 C400 3D00 4600 C980 0000
5BFF 3C00 3C00 C200 DBFE 0400 4000 3E00 3000 3C00 4200 BE00
3C00 3C01 6800 4700 1000 1000 3C00 3800 3C00 3C01 6800 4780
7C00 FC00 0000 8000 3C00 4500 4200 BC00 7C00 FC00 4200 BC00
8000 0000 8000 7C00 8000 8000 0000 7C00 8000 0000 0000 7C00
7BFF FBFF 0401 8401 7BFF FBFF 8400 0400 7C00 FC00 0000 8000
7E00 7C00 7C01 3C00 3C00 FC00 4000 7E00 7E00 7E00 7E00 7E00

/* compile.f */
verilog/fpv_pkg.sv
verilog/fp16_add_lane.sv
verilog/fpv_issue.sv
verilog/fpv_collect.sv
verilog/fpv_axil_regs.sv
verilog/fpv_top.sv
verification/tb_clkgen.sv
verification/tb_fpv_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fp16 vector adder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpv_top \
    -Mdir obj_dir -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_fpv_top > sim.log 2>&1 || true

grep -qx "No errors" sim.log && echo "Simulation passed" \
    || { cat sim.log; echo "Simulation failed"; exit 1; }
